/* include/backend_consts.svh */
// integer back end sizing; ROB_DEPTH must stay a power of two, XLEN must be at least IMM_LEN
`ifndef BACKEND_CONSTS_SVH
`define BACKEND_CONSTS_SVH

// data word width
`define XLEN 32

// integer registers, x0 included
`define REG_N 32

// reorder buffer entries
`define ROB_DEPTH 8

// immediate field width, sign-extended at use
`define IMM_LEN 12

`endif

/* logic/isa_pkg.sv */
// instruction-level types for the integer back end; opcode encoding is fixed to 3 bits
`include "backend_consts.svh"

package isa_pkg;

    // one data word as held in registers and ROB
    typedef logic [`XLEN-1:0] word_t;

    // architectural register index
    typedef logic [$clog2(`REG_N)-1:0] reg_idx_t;

    // raw immediate, the issue stage sign-extends it
    typedef logic [`IMM_LEN-1:0] imm_t;

    // alu operations
    // shifts use only the low five bits of operand b
    // slt is signed and returns 1 or 0
    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_AND = 3'd2,
        OP_OR  = 3'd3,
        OP_XOR = 3'd4,
        OP_SLL = 3'd5,
        OP_SRL = 3'd6,
        OP_SLT = 3'd7
    } alu_op_t;

endpackage

/* logic/rob_pkg.sv */
// reorder buffer bookkeeping types; index width follows ROB_DEPTH which must be a power of two
`include "backend_consts.svh"

package rob_pkg;

    // entry index, wraps naturally at the buffer size
    typedef logic [$clog2(`ROB_DEPTH)-1:0] rob_idx_t;

    // occupancy counter, one bit wider than the index to hold a full buffer
    typedef logic [$clog2(`ROB_DEPTH):0] rob_cnt_t;

    // life cycle of an entry
    // free -> wait at allocation
    // wait -> done at alu write-back
    // done -> free at commit
    typedef enum logic [1:0] {
        ROB_FREE = 2'd0,
        ROB_WAIT = 2'd1,
        ROB_DONE = 2'd2
    } rob_state_t;

endpackage

/* logic/int_rf.sv */
// integer register file; reads are combinational with no write-through, x0 is hardwired to zero
`timescale 1ns/1ps
`include "backend_consts.svh"

module int_rf import isa_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_n_i,
    // operand read ports
    input  reg_idx_t rs1_i,
    input  reg_idx_t rs2_i,
    output word_t    rs1_value_o,
    output word_t    rs2_value_o,
    // commit write port
    input  logic     wr_en_i,
    input  reg_idx_t wr_rd_i,
    input  word_t    wr_value_i
);

    // x0 has no storage
    word_t regs_q [1:`REG_N-1];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            // all registers start at zero
            for (int i = 1; i < `REG_N; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_en_i && (wr_rd_i != '0)) begin
            // writes to x0 are dropped
            regs_q[wr_rd_i] <= wr_value_i;
        end
    end

    // x0 always reads zero
    assign rs1_value_o = (rs1_i == '0) ? '0 : regs_q[rs1_i];
    assign rs2_value_o = (rs2_i == '0) ? '0 : regs_q[rs2_i];

endmodule

/* logic/reg_status.sv */
// register status table; one producer per register, a same-cycle issue beats the commit clear
`timescale 1ns/1ps
`include "backend_consts.svh"

module reg_status import isa_pkg::*; import rob_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_n_i,
    // rename request from issue
    input  logic     issue_valid_i,
    input  reg_idx_t issue_rd_i,
    input  rob_idx_t issue_tag_i,
    // source lookups
    input  reg_idx_t rs1_i,
    input  reg_idx_t rs2_i,
    output logic     rs1_busy_o,
    output logic     rs2_busy_o,
    output rob_idx_t rs1_tag_o,
    output rob_idx_t rs2_tag_o,
    // retire notification
    input  logic     comm_valid_i,
    input  reg_idx_t comm_rd_i,
    input  rob_idx_t comm_tag_i
);

    logic [`REG_N-1:0] busy_q;
    rob_idx_t          tag_q [`REG_N];

    logic set_en;
    logic clr_en;

    // x0 is never renamed
    assign set_en = issue_valid_i && (issue_rd_i != '0);

    // only the latest producer may release the register
    assign clr_en = comm_valid_i && busy_q[comm_rd_i] && (tag_q[comm_rd_i] == comm_tag_i);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_q <= '0;
        end else begin
            if (clr_en) begin
                busy_q[comm_rd_i] <= 1'b0;
            end
            // placed after the clear so that a new rename of the same register wins
            if (set_en) begin
                busy_q[issue_rd_i] <= 1'b1;
            end
        end
    end

    // producer tags, meaningful only while busy
    always_ff @(posedge clk_i) begin
        if (set_en) begin
            tag_q[issue_rd_i] <= issue_tag_i;
        end
    end

    assign rs1_busy_o = busy_q[rs1_i];
    assign rs2_busy_o = busy_q[rs2_i];
    assign rs1_tag_o  = tag_q[rs1_i];
    assign rs2_tag_o  = tag_q[rs2_i];

    // x0 must stay available whatever issue and commit do
    x0_never_busy: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) !busy_q[0]
    );

endmodule

/* logic/issue_stage.sv */
// in-order issue; stalls on any unfinished source since there are no reservation stations
`timescale 1ns/1ps

module issue_stage import isa_pkg::*; import rob_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_n_i,
    // instruction from fetch
    input  logic     fetch_valid_i,
    input  alu_op_t  fetch_op_i,
    input  reg_idx_t fetch_rd_i,
    input  reg_idx_t fetch_rs1_i,
    input  reg_idx_t fetch_rs2_i,
    input  imm_t     fetch_imm_i,
    input  logic     fetch_use_imm_i,
    output logic     fetch_ready_o,
    // rob allocation and operand lookup
    input  rob_idx_t rob_tail_i,
    input  logic     rob_full_i,
    output rob_idx_t rob_rs1_tag_o,
    output rob_idx_t rob_rs2_tag_o,
    input  logic     rob_rs1_done_i,
    input  logic     rob_rs2_done_i,
    input  word_t    rob_rs1_value_i,
    input  word_t    rob_rs2_value_i,
    output logic     alloc_o,
    output reg_idx_t alloc_rd_o,
    // dispatch to the alu
    output logic     ex_valid_o,
    output alu_op_t  ex_op_o,
    output word_t    ex_opa_o,
    output word_t    ex_opb_o,
    output rob_idx_t ex_tag_o,
    // retiring entry
    input  logic     comm_valid_i,
    input  reg_idx_t comm_rd_i,
    input  word_t    comm_value_i,
    input  rob_idx_t comm_tag_i
);

    logic  rs1_busy;
    logic  rs2_busy;
    word_t rf_rs1_value;
    word_t rf_rs2_value;
    word_t imm_sext;
    logic  rs1_avail;
    logic  rs2_avail;
    logic  accept;

    reg_status u_reg_status (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .issue_valid_i(accept),
        .issue_rd_i   (fetch_rd_i),
        .issue_tag_i  (rob_tail_i),
        .rs1_i        (fetch_rs1_i),
        .rs2_i        (fetch_rs2_i),
        .rs1_busy_o   (rs1_busy),
        .rs2_busy_o   (rs2_busy),
        .rs1_tag_o    (rob_rs1_tag_o),
        .rs2_tag_o    (rob_rs2_tag_o),
        .comm_valid_i (comm_valid_i),
        .comm_rd_i    (comm_rd_i),
        .comm_tag_i   (comm_tag_i)
    );

    int_rf u_int_rf (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .rs1_i      (fetch_rs1_i),
        .rs2_i      (fetch_rs2_i),
        .rs1_value_o(rf_rs1_value),
        .rs2_value_o(rf_rs2_value),
        .wr_en_i    (comm_valid_i),
        .wr_rd_i    (comm_rd_i),
        .wr_value_i (comm_value_i)
    );

    // a source is usable from the rf when idle, from the rob once its producer is done
    // x0 is never busy so it is always available
    assign rs1_avail = !rs1_busy || rob_rs1_done_i;
    assign rs2_avail = fetch_use_imm_i || !rs2_busy || rob_rs2_done_i;

    assign fetch_ready_o = !rob_full_i && rs1_avail && rs2_avail;
    assign accept        = fetch_valid_i && fetch_ready_o;

    assign imm_sext = {{($bits(word_t) - $bits(imm_t)){fetch_imm_i[$bits(imm_t)-1]}}, fetch_imm_i};

    // every accepted instruction takes the tail entry
    assign alloc_o    = accept;
    assign alloc_rd_o = fetch_rd_i;

    // operand muxes
    assign ex_opa_o = rs1_busy ? rob_rs1_value_i : rf_rs1_value;
    assign ex_opb_o = fetch_use_imm_i ? imm_sext : (rs2_busy ? rob_rs2_value_i : rf_rs2_value);

    assign ex_valid_o = accept;
    assign ex_op_o    = fetch_op_i;
    assign ex_tag_o   = rob_tail_i;

endmodule

/* logic/alu_pipe.sv */
// two-stage integer alu with no stall input; a result appears exactly two cycles after dispatch
`timescale 1ns/1ps

module alu_pipe import isa_pkg::*; import rob_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  logic     in_valid_i,
    input  alu_op_t  in_op_i,
    input  word_t    in_opa_i,
    input  word_t    in_opb_i,
    input  rob_idx_t in_tag_i,
    output logic     out_valid_o,
    output rob_idx_t out_tag_o,
    output word_t    out_result_o
);

    localparam int MSB = $bits(word_t) - 1;

    // stage one holds operands and decoded controls
    logic     s1_valid_q;
    alu_op_t  s1_op_q;
    word_t    s1_opa_q;
    word_t    s1_opb_q;
    rob_idx_t s1_tag_q;
    logic     s1_sub_q;
    logic [4:0] s1_shamt_q;

    word_t addsub;
    logic  slt_bit;
    word_t result;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            s1_valid_q  <= 1'b0;
            out_valid_o <= 1'b0;
        end else begin
            s1_valid_q  <= in_valid_i;
            out_valid_o <= s1_valid_q;
        end
    end

    always_ff @(posedge clk_i) begin
        s1_op_q    <= in_op_i;
        s1_opa_q   <= in_opa_i;
        s1_opb_q   <= in_opb_i;
        s1_tag_q   <= in_tag_i;
        // sub and slt share the subtracting adder
        s1_sub_q   <= (in_op_i == OP_SUB) || (in_op_i == OP_SLT);
        s1_shamt_q <= in_opb_i[4:0];
    end

    // a - b computed as a + ~b + 1
    assign addsub = s1_opa_q + (s1_opb_q ^ {$bits(word_t){s1_sub_q}}) + word_t'(s1_sub_q);

    // signs differ, so a is less exactly when it is negative
    assign slt_bit = (s1_opa_q[MSB] != s1_opb_q[MSB]) ? s1_opa_q[MSB] : addsub[MSB];

    always_comb begin
        case (s1_op_q)
            OP_ADD,
            OP_SUB:  result = addsub;
            OP_AND:  result = s1_opa_q & s1_opb_q;
            OP_OR:   result = s1_opa_q | s1_opb_q;
            OP_XOR:  result = s1_opa_q ^ s1_opb_q;
            OP_SLL:  result = s1_opa_q << s1_shamt_q;
            OP_SRL:  result = s1_opa_q >> s1_shamt_q;
            OP_SLT:  result = word_t'(slt_bit);
            default: result = '0;
        endcase
    end

    // stage two result register
    always_ff @(posedge clk_i) begin
        out_tag_o    <= s1_tag_q;
        out_result_o <= result;
    end

    // each dispatch returns its own tag two cycles later
    valid_two_later: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        in_valid_i |-> ##2 (out_valid_o && (out_tag_o == $past(in_tag_i, 2)))
    );

    // and nothing comes out that was not dispatched
    no_spurious_out: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        out_valid_o |-> $past(in_valid_i, 2)
    );

endmodule

/* logic/rob.sv */
// circular reorder buffer; one retire per cycle with no flush and no back-pressure on commit
`timescale 1ns/1ps
`include "backend_consts.svh"

module rob import isa_pkg::*; import rob_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_n_i,
    // allocation at the tail
    input  logic     alloc_i,
    input  reg_idx_t alloc_rd_i,
    output rob_idx_t tail_o,
    output logic     full_o,
    // operand forwarding lookups
    input  rob_idx_t rs1_tag_i,
    input  rob_idx_t rs2_tag_i,
    output logic     rs1_done_o,
    output logic     rs2_done_o,
    output word_t    rs1_value_o,
    output word_t    rs2_value_o,
    // completion from the alu
    input  logic     wb_valid_i,
    input  rob_idx_t wb_tag_i,
    input  word_t    wb_value_i,
    // in-order retire
    output logic     comm_valid_o,
    output reg_idx_t comm_rd_o,
    output word_t    comm_value_o,
    output rob_idx_t comm_tag_o
);

    rob_state_t state_q [`ROB_DEPTH];
    reg_idx_t   rd_q    [`ROB_DEPTH];
    word_t      value_q [`ROB_DEPTH];

    rob_idx_t head_q;
    rob_idx_t tail_q;
    rob_cnt_t count_q;

    // the head retires as soon as its result is in
    assign comm_valid_o = (state_q[head_q] == ROB_DONE);
    assign comm_rd_o    = rd_q[head_q];
    assign comm_value_o = value_q[head_q];
    assign comm_tag_o   = head_q;

    assign tail_o = tail_q;
    assign full_o = (count_q == rob_cnt_t'(`ROB_DEPTH));

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `ROB_DEPTH; i++) begin
                state_q[i] <= ROB_FREE;
            end
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (alloc_i) begin
                state_q[tail_q] <= ROB_WAIT;
                tail_q          <= tail_q + 1'b1;
            end
            if (wb_valid_i) begin
                state_q[wb_tag_i] <= ROB_DONE;
            end
            if (comm_valid_o) begin
                state_q[head_q] <= ROB_FREE;
                head_q          <= head_q + 1'b1;
            end
            // allocate and retire in the same cycle leaves the count unchanged
            count_q <= count_q + rob_cnt_t'(alloc_i) - rob_cnt_t'(comm_valid_o);
        end
    end

    // destination and result payload
    always_ff @(posedge clk_i) begin
        if (alloc_i) begin
            rd_q[tail_q] <= alloc_rd_i;
        end
        if (wb_valid_i) begin
            value_q[wb_tag_i] <= wb_value_i;
        end
    end

    // forwarding is valid only once the entry has completed
    assign rs1_done_o  = (state_q[rs1_tag_i] == ROB_DONE);
    assign rs2_done_o  = (state_q[rs2_tag_i] == ROB_DONE);
    assign rs1_value_o = value_q[rs1_tag_i];
    assign rs2_value_o = value_q[rs2_tag_i];

    // issue must respect full
    no_alloc_when_full: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) alloc_i |-> !full_o
    );

    // the alu may only complete an entry that is still waiting
    wb_to_waiting_entry: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) wb_valid_i |-> (state_q[wb_tag_i] == ROB_WAIT)
    );

endmodule

/* logic/back_end.sv */
// integer-only back end top; commit is a one-cycle pulse and fetch_ready_o is the only stall
`timescale 1ns/1ps

module back_end import isa_pkg::*; import rob_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_n_i,
    // fetch side
    input  logic     fetch_valid_i,
    input  alu_op_t  fetch_op_i,
    input  reg_idx_t fetch_rd_i,
    input  reg_idx_t fetch_rs1_i,
    input  reg_idx_t fetch_rs2_i,
    input  imm_t     fetch_imm_i,
    input  logic     fetch_use_imm_i,
    output logic     fetch_ready_o,
    // commit side
    output logic     comm_valid_o,
    output reg_idx_t comm_rd_o,
    output word_t    comm_value_o
);

    // issue and rob
    rob_idx_t rob_tail;
    logic     rob_full;
    rob_idx_t rob_rs1_tag;
    rob_idx_t rob_rs2_tag;
    logic     rob_rs1_done;
    logic     rob_rs2_done;
    word_t    rob_rs1_value;
    word_t    rob_rs2_value;
    logic     alloc;
    reg_idx_t alloc_rd;

    // issue to alu
    logic     ex_valid;
    alu_op_t  ex_op;
    word_t    ex_opa;
    word_t    ex_opb;
    rob_idx_t ex_tag;

    // alu write-back and retiring tag
    logic     wb_valid;
    rob_idx_t wb_tag;
    word_t    wb_value;
    rob_idx_t comm_tag;

    issue_stage u_issue_stage (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .fetch_valid_i  (fetch_valid_i),
        .fetch_op_i     (fetch_op_i),
        .fetch_rd_i     (fetch_rd_i),
        .fetch_rs1_i    (fetch_rs1_i),
        .fetch_rs2_i    (fetch_rs2_i),
        .fetch_imm_i    (fetch_imm_i),
        .fetch_use_imm_i(fetch_use_imm_i),
        .fetch_ready_o  (fetch_ready_o),
        .rob_tail_i     (rob_tail),
        .rob_full_i     (rob_full),
        .rob_rs1_tag_o  (rob_rs1_tag),
        .rob_rs2_tag_o  (rob_rs2_tag),
        .rob_rs1_done_i (rob_rs1_done),
        .rob_rs2_done_i (rob_rs2_done),
        .rob_rs1_value_i(rob_rs1_value),
        .rob_rs2_value_i(rob_rs2_value),
        .alloc_o        (alloc),
        .alloc_rd_o     (alloc_rd),
        .ex_valid_o     (ex_valid),
        .ex_op_o        (ex_op),
        .ex_opa_o       (ex_opa),
        .ex_opb_o       (ex_opb),
        .ex_tag_o       (ex_tag),
        .comm_valid_i   (comm_valid_o),
        .comm_rd_i      (comm_rd_o),
        .comm_value_i   (comm_value_o),
        .comm_tag_i     (comm_tag)
    );

    alu_pipe u_alu_pipe (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .in_valid_i  (ex_valid),
        .in_op_i     (ex_op),
        .in_opa_i    (ex_opa),
        .in_opb_i    (ex_opb),
        .in_tag_i    (ex_tag),
        .out_valid_o (wb_valid),
        .out_tag_o   (wb_tag),
        .out_result_o(wb_value)
    );

    // single execution unit writes the rob directly
    rob u_rob (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .alloc_i     (alloc),
        .alloc_rd_i  (alloc_rd),
        .tail_o      (rob_tail),
        .full_o      (rob_full),
        .rs1_tag_i   (rob_rs1_tag),
        .rs2_tag_i   (rob_rs2_tag),
        .rs1_done_o  (rob_rs1_done),
        .rs2_done_o  (rob_rs2_done),
        .rs1_value_o (rob_rs1_value),
        .rs2_value_o (rob_rs2_value),
        .wb_valid_i  (wb_valid),
        .wb_tag_i    (wb_tag),
        .wb_value_i  (wb_value),
        .comm_valid_o(comm_valid_o),
        .comm_rd_o   (comm_rd_o),
        .comm_value_o(comm_value_o),
        .comm_tag_o  (comm_tag)
    );

endmodule

/* dv/tb_clk_gen.sv */
// testbench clock and reset source; reset is released just after a rising edge, never on one
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter real PERIOD_NS  = 100.0,
    parameter int  RST_CYCLES = 8
) (
    output logic clk_o,
    output logic rst_n_o
);

    // free running clock
    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
    end

    // reset held low for a fixed number of rising edges
    initial begin
        rst_n_o = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        #1 rst_n_o = 1'b1;
    end

endmodule

/* dv/tb_back_end.sv */
// back end testbench; assumes in-order commit, ROB_DEPTH entries and a fixed $urandom seed
`timescale 1ns/1ps
`include "backend_consts.svh"

module tb_back_end import isa_pkg::*; ();

    localparam int MAX_ROWS       = 128;
    localparam int RAND_ROWS      = 64;
    localparam int RESET_TIMEOUT  = 50;
    localparam int ACCEPT_TIMEOUT = 200;
    localparam int DRAIN_TIMEOUT  = 500;
    localparam int DRIVE_DELAY    = 5;

    logic     clk;
    logic     rst_n;
    logic     fetch_valid;
    alu_op_t  fetch_op;
    reg_idx_t fetch_rd;
    reg_idx_t fetch_rs1;
    reg_idx_t fetch_rs2;
    imm_t     fetch_imm;
    logic     fetch_use_imm;
    logic     fetch_ready;
    logic     comm_valid;
    reg_idx_t comm_rd;
    word_t    comm_value;

    // program table
    alu_op_t  tbl_op      [MAX_ROWS];
    reg_idx_t tbl_rd      [MAX_ROWS];
    reg_idx_t tbl_rs1     [MAX_ROWS];
    reg_idx_t tbl_rs2     [MAX_ROWS];
    imm_t     tbl_imm     [MAX_ROWS];
    logic     tbl_use_imm [MAX_ROWS];
    int       row_count     = 0;
    int       directed_rows = 0;

    // architectural state of the reference model and expected commits in order
    word_t    ref_regs [`REG_N];
    reg_idx_t exp_rd_q [$];
    word_t    exp_val_q [$];

    int value_errors = 0;
    int other_errors = 0;
    int commit_count = 0;
    bit aborted      = 1'b0;

    tb_clk_gen #(.PERIOD_NS(100.0), .RST_CYCLES(8)) u_clk_gen (
        .clk_o  (clk),
        .rst_n_o(rst_n)
    );

    back_end dut0 (
        .clk_i          (clk),
        .rst_n_i        (rst_n),
        .fetch_valid_i  (fetch_valid),
        .fetch_op_i     (fetch_op),
        .fetch_rd_i     (fetch_rd),
        .fetch_rs1_i    (fetch_rs1),
        .fetch_rs2_i    (fetch_rs2),
        .fetch_imm_i    (fetch_imm),
        .fetch_use_imm_i(fetch_use_imm),
        .fetch_ready_o  (fetch_ready),
        .comm_valid_o   (comm_valid),
        .comm_rd_o      (comm_rd),
        .comm_value_o   (comm_value)
    );

    task automatic add_row(input alu_op_t op, input reg_idx_t rd, input reg_idx_t rs1,
                           input reg_idx_t rs2, input imm_t imm, input logic use_imm);
        tbl_op[row_count]      = op;
        tbl_rd[row_count]      = rd;
        tbl_rs1[row_count]     = rs1;
        tbl_rs2[row_count]     = rs2;
        tbl_imm[row_count]     = imm;
        tbl_use_imm[row_count] = use_imm;
        row_count++;
    endtask

    function automatic word_t sext_imm(input imm_t imm);
        return {{(`XLEN - `IMM_LEN){imm[`IMM_LEN-1]}}, imm};
    endfunction

    // opcode rules with shifts by the low five bits and a signed slt
    function automatic word_t alu_ref(input alu_op_t op, input word_t a, input word_t b);
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_SLL:  return a << b[4:0];
            OP_SRL:  return a >> b[4:0];
            OP_SLT:  return ($signed(a) < $signed(b)) ? word_t'(1) : word_t'(0);
            default: return '0;
        endcase
    endfunction

    // runs one row against the model when the DUT takes it
    task automatic model_accept(input int row);
        word_t a;
        word_t b;
        word_t res;
        a   = ref_regs[tbl_rs1[row]];
        b   = tbl_use_imm[row] ? sext_imm(tbl_imm[row]) : ref_regs[tbl_rs2[row]];
        res = alu_ref(tbl_op[row], a, b);
        // x0 keeps reading zero but the commit still reports the result
        if (tbl_rd[row] != '0) begin
            ref_regs[tbl_rd[row]] = res;
        end
        exp_rd_q.push_back(tbl_rd[row]);
        exp_val_q.push_back(res);
    endtask

    task automatic check_reg_idx(input string name, input reg_idx_t got, input reg_idx_t exp);
        if (got !== exp) begin
            $display("FAIL %s: got 0x%h expected 0x%h at %0t", name, got, exp, $time);
            value_errors++;
        end
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("FAIL %s: got 0x%h expected 0x%h at %0t", name, got, exp, $time);
            value_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL %s: got 0x%h expected 0x%h at %0t", name, got, exp, $time);
            value_errors++;
        end
    endtask

    // holds one row on the fetch ports until accepted
    // ready is looked at mid-cycle
    task automatic apply_row(input int row, output bit timed_out);
        int waited;
        bit taken;
        waited    = 0;
        taken     = 1'b0;
        timed_out = 1'b0;
        fetch_valid   = 1'b1;
        fetch_op      = tbl_op[row];
        fetch_rd      = tbl_rd[row];
        fetch_rs1     = tbl_rs1[row];
        fetch_rs2     = tbl_rs2[row];
        fetch_imm     = tbl_imm[row];
        fetch_use_imm = tbl_use_imm[row];
        while (!taken && !timed_out) begin
            @(negedge clk);
            if (fetch_ready === 1'b1) begin
                taken = 1'b1;
            end else if (waited >= ACCEPT_TIMEOUT) begin
                timed_out = 1'b1;
            end else begin
                waited++;
            end
        end
        // the acceptance edge
        @(posedge clk);
        if (taken) begin
            model_accept(row);
        end else begin
            $display("row %0d was not accepted within %0d cycles", row, ACCEPT_TIMEOUT);
            other_errors++;
        end
        #DRIVE_DELAY;
        fetch_valid = 1'b0;
    endtask

    // each commit is taken at the rising edge after this sample
    always @(negedge clk) begin : commit_monitor
        reg_idx_t want_rd;
        word_t    want_val;
        if (rst_n === 1'b1 && comm_valid === 1'b1) begin
            commit_count++;
            if (exp_rd_q.size() == 0) begin
                $display("commit of x%0d at %0t arrived with nothing outstanding", comm_rd, $time);
                other_errors++;
            end else begin
                want_rd  = exp_rd_q.pop_front();
                want_val = exp_val_q.pop_front();
                check_reg_idx("comm_rd_o", comm_rd, want_rd);
                check_word("comm_value_o", comm_value, want_val);
            end
        end
    end

    initial begin : stimulus
        int          gap;
        int          waited;
        bit          timed_out;
        int          row;

        fetch_valid   = 1'b0;
        fetch_op      = OP_ADD;
        fetch_rd      = '0;
        fetch_rs1     = '0;
        fetch_rs2     = '0;
        fetch_imm     = '0;
        fetch_use_imm = 1'b0;
        for (int i = 0; i < `REG_N; i++) begin
            ref_regs[i] = '0;
        end
        void'($urandom(32'h45c63289));

        // x5 must read zero straight after reset
        add_row(OP_OR,  5'd5,  5'd5,  5'd0, 12'h000, 1'b1);
        // operand setup
        add_row(OP_ADD, 5'd1,  5'd0,  5'd0, 12'd100, 1'b1);
        add_row(OP_ADD, 5'd2,  5'd0,  5'd0, 12'hff9, 1'b1);
        add_row(OP_OR,  5'd3,  5'd0,  5'd0, 12'h5a5, 1'b1);
        add_row(OP_ADD, 5'd4,  5'd0,  5'd0, 12'h003, 1'b1);
        // every opcode with registers and immediates
        add_row(OP_ADD, 5'd6,  5'd1,  5'd2, 12'h000, 1'b0);
        add_row(OP_SUB, 5'd7,  5'd1,  5'd3, 12'h000, 1'b0);
        add_row(OP_AND, 5'd8,  5'd3,  5'd0, 12'h0f0, 1'b1);
        add_row(OP_OR,  5'd9,  5'd1,  5'd3, 12'h000, 1'b0);
        add_row(OP_XOR, 5'd10, 5'd3,  5'd0, 12'h7ff, 1'b1);
        add_row(OP_SLL, 5'd11, 5'd3,  5'd4, 12'h000, 1'b0);
        add_row(OP_SRL, 5'd12, 5'd2,  5'd0, 12'h004, 1'b1);
        add_row(OP_SLT, 5'd13, 5'd2,  5'd1, 12'h000, 1'b0);
        add_row(OP_SLT, 5'd14, 5'd1,  5'd2, 12'h000, 1'b0);
        // shift amount above 31 wraps to its low five bits
        add_row(OP_SLL, 5'd15, 5'd1,  5'd0, 12'h023, 1'b1);
        add_row(OP_SRL, 5'd23, 5'd2,  5'd4, 12'h000, 1'b0);
        add_row(OP_SUB, 5'd24, 5'd2,  5'd0, 12'h800, 1'b1);
        // back-to-back read-after-write chain
        add_row(OP_ADD, 5'd16, 5'd1,  5'd0, 12'h001, 1'b1);
        add_row(OP_ADD, 5'd16, 5'd16, 5'd0, 12'h001, 1'b1);
        add_row(OP_ADD, 5'd16, 5'd16, 5'd16, 12'h000, 1'b0);
        add_row(OP_SUB, 5'd17, 5'd16, 5'd1, 12'h000, 1'b0);
        add_row(OP_XOR, 5'd18, 5'd17, 5'd16, 12'h000, 1'b0);
        add_row(OP_AND, 5'd19, 5'd18, 5'd17, 12'h000, 1'b0);
        add_row(OP_SLT, 5'd20, 5'd0,  5'd19, 12'h000, 1'b0);
        // x0 as destination then as source
        add_row(OP_ADD, 5'd0,  5'd1,  5'd0, 12'h005, 1'b1);
        add_row(OP_OR,  5'd21, 5'd0,  5'd0, 12'h123, 1'b1);
        add_row(OP_ADD, 5'd22, 5'd0,  5'd0, 12'h000, 1'b0);
        directed_rows = row_count;

        // random tail on low registers so dependencies are common
        for (int i = 0; i < RAND_ROWS; i++) begin
            add_row(alu_op_t'($urandom_range(0, 7)), reg_idx_t'($urandom_range(0, 15)),
                    reg_idx_t'($urandom_range(0, 15)), reg_idx_t'($urandom_range(0, 15)),
                    imm_t'($urandom), logic'($urandom_range(0, 1)));
        end

        waited = 0;
        while (rst_n !== 1'b1 && waited < RESET_TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (rst_n !== 1'b1) begin
            $display("reset was not released within %0d cycles", RESET_TIMEOUT);
            other_errors++;
            aborted = 1'b1;
        end else begin
            @(posedge clk);
            #DRIVE_DELAY;
            check_flag("comm_valid_o", comm_valid, 1'b0);
            check_flag("fetch_ready_o", fetch_ready, 1'b1);
        end

        row = 0;
        while (!aborted && row < row_count) begin
            if (row >= directed_rows) begin
                gap = $urandom_range(0, 3);
                repeat (gap) @(posedge clk);
                if (gap > 0) begin
                    #DRIVE_DELAY;
                end
            end
            apply_row(row, timed_out);
            if (timed_out) begin
                aborted = 1'b1;
            end
            row++;
        end

        waited = 0;
        while (!aborted && exp_rd_q.size() > 0 && waited < DRAIN_TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (exp_rd_q.size() > 0) begin
            $display("%0d commits still missing when the run ended", exp_rd_q.size());
            other_errors++;
        end
        // quiet window so a late extra commit is seen
        repeat (20) @(posedge clk);
        if (commit_count != row_count) begin
            $display("saw %0d commits for %0d program rows", commit_count, row_count);
            other_errors++;
        end

        $display("errors: %0d value, %0d other; %0d commits", value_errors, other_errors,
                 commit_count);
        if (value_errors + other_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* flist.f */
+incdir+include
logic/isa_pkg.sv
logic/rob_pkg.sv
logic/int_rf.sv
logic/reg_status.sv
logic/issue_stage.sv
logic/alu_pipe.sv
logic/rob.sv
logic/back_end.sv
dv/tb_clk_gen.sv
dv/tb_back_end.sv

/* Bender.yml */
package:
  name: back_end

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/isa_pkg.sv
      - logic/rob_pkg.sv
      - logic/int_rf.sv
      - logic/reg_status.sv
      - logic/issue_stage.sv
      - logic/alu_pipe.sv
      - logic/rob.sv
      - logic/back_end.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/tb_clk_gen.sv
      - dv/tb_back_end.sv
